/* hw/rv_decode_pkg.sv */
// ----------------------------------------------------------
// RV32I decode stage shared definitions
// Widths, reset vector, major opcodes and the encodings of
// the control fields passed from decode to execute
// ----------------------------------------------------------

`default_nettype none

package rv_decode_pkg;

	// ----------------------------------------------------------
	// Widths and constants

	localparam int XLEN      = 32;
	localparam int REGADDR_W = 5;

	// First instruction fetched after reset
	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0040;

	// Every instruction is one word long
	localparam logic [XLEN-1:0] INSTR_BYTES = 32'h0000_0004;

	localparam logic [REGADDR_W-1:0] REG_X0 = '0;

	// Bits 1:0 of every 32-bit encoding
	localparam logic [1:0] OPCODE_LOW = 2'b11;

	// funct7 values accepted by OP and the shift immediates
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// ----------------------------------------------------------
	// Major opcode, instruction bits 6:2

	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011
	} opcode_t;

	// ----------------------------------------------------------
	// Execute control fields

	typedef enum logic {
		ALUSRCA_RS1 = 1'b0,
		ALUSRCA_PC  = 1'b1
	} alusrc_a_t;

	typedef enum logic {
		ALUSRCB_RS2 = 1'b0,
		ALUSRCB_IMM = 1'b1
	} alusrc_b_t;

	typedef enum logic [3:0] {
		ALUOP_ADD = 4'h0,
		ALUOP_SUB = 4'h1,
		ALUOP_SLL = 4'h2,
		ALUOP_LT  = 4'h3,
		ALUOP_LTU = 4'h4,
		ALUOP_XOR = 4'h5,
		ALUOP_SRL = 4'h6,
		ALUOP_SRA = 4'h7,
		ALUOP_OR  = 4'h8,
		ALUOP_AND = 4'h9,
		// Pass the second operand through unchanged
		ALUOP_RS2 = 4'ha
	} aluop_t;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'h0,
		MEMOP_LB   = 4'h1,
		MEMOP_LH   = 4'h2,
		MEMOP_LW   = 4'h3,
		MEMOP_LBU  = 4'h4,
		MEMOP_LHU  = 4'h5,
		MEMOP_SB   = 4'h6,
		MEMOP_SH   = 4'h7,
		MEMOP_SW   = 4'h8
	} memop_t;

	// Taken condition, evaluated on the ALU result
	typedef enum logic [1:0] {
		BCOND_NEVER  = 2'b00,
		BCOND_ZERO   = 2'b01,
		BCOND_NZERO  = 2'b10,
		BCOND_ALWAYS = 2'b11
	} bcond_t;

	typedef enum logic [1:0] {
		EXCEPT_NONE          = 2'b00,
		EXCEPT_INSTR_ILLEGAL = 2'b01,
		EXCEPT_INSTR_FAULT   = 2'b10
	} except_t;

	// ----------------------------------------------------------
	// Immediate selects from decoder to immediate generator

	typedef enum logic [1:0] {
		IMM_SEL_I    = 2'b00,
		IMM_SEL_U    = 2'b01,
		IMM_SEL_LINK = 2'b10
	} imm_sel_t;

	typedef enum logic [2:0] {
		OFFS_SEL_I    = 3'd0,
		OFFS_SEL_S    = 3'd1,
		OFFS_SEL_B    = 3'd2,
		OFFS_SEL_J    = 3'd3,
		OFFS_SEL_FOUR = 3'd4,
		OFFS_SEL_ZERO = 3'd5
	} offs_sel_t;

endpackage

`default_nettype wire

/* hw/rv_imm_gen.sv */
// ----------------------------------------------------------
// Immediate generator
// Builds the five RV32I immediate formats and picks the
// execute immediate and the address offset
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rv_imm_gen (
	input  wire  [rv_decode_pkg::XLEN-1:0] instr_i,
	input  wire  rv_decode_pkg::imm_sel_t  imm_sel_i,
	input  wire  rv_decode_pkg::offs_sel_t offs_sel_i,
	output logic [rv_decode_pkg::XLEN-1:0] d_imm_o,
	output logic [rv_decode_pkg::XLEN-1:0] d_addr_offs_o
);

	logic [rv_decode_pkg::XLEN-1:0] imm_i;
	logic [rv_decode_pkg::XLEN-1:0] imm_s;
	logic [rv_decode_pkg::XLEN-1:0] imm_b;
	logic [rv_decode_pkg::XLEN-1:0] imm_u;
	logic [rv_decode_pkg::XLEN-1:0] imm_j;

	// Sign bit is always instruction bit 31
	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	always_comb begin
		case (imm_sel_i)
		rv_decode_pkg::IMM_SEL_I:    d_imm_o = imm_i;
		rv_decode_pkg::IMM_SEL_U:    d_imm_o = imm_u;
		// Link value is the address of the next instruction relative to PC
		rv_decode_pkg::IMM_SEL_LINK: d_imm_o = rv_decode_pkg::INSTR_BYTES;
		default:                     d_imm_o = '0;
		endcase
	end

	always_comb begin
		case (offs_sel_i)
		rv_decode_pkg::OFFS_SEL_I:    d_addr_offs_o = imm_i;
		rv_decode_pkg::OFFS_SEL_S:    d_addr_offs_o = imm_s;
		rv_decode_pkg::OFFS_SEL_B:    d_addr_offs_o = imm_b;
		rv_decode_pkg::OFFS_SEL_J:    d_addr_offs_o = imm_j;
		rv_decode_pkg::OFFS_SEL_FOUR: d_addr_offs_o = rv_decode_pkg::INSTR_BYTES;
		default:                      d_addr_offs_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/rv_op_decoder.sv */
// ----------------------------------------------------------
// RV32I operation decoder
// Maps the current instruction word to execute control
// fields, flags illegal encodings and squashes the fields
// on starvation, bus faults and illegal instructions
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rv_op_decoder (
	input  wire  [rv_decode_pkg::XLEN-1:0]      instr_i,
	input  wire                                 starved_i,
	input  wire                                 fd_cir_vld_i,
	input  wire                                 fd_cir_err_i,
	input  wire                                 lock_prev_i,
	output logic [rv_decode_pkg::REGADDR_W-1:0] d_rs1_o,
	output logic [rv_decode_pkg::REGADDR_W-1:0] d_rs2_o,
	output logic [rv_decode_pkg::REGADDR_W-1:0] d_rd_o,
	output rv_decode_pkg::alusrc_a_t            d_alusrc_a_o,
	output rv_decode_pkg::alusrc_b_t            d_alusrc_b_o,
	output rv_decode_pkg::aluop_t               d_aluop_o,
	output rv_decode_pkg::memop_t               d_memop_o,
	output rv_decode_pkg::bcond_t               d_branchcond_o,
	output logic                                d_addr_is_regoffs_o,
	output rv_decode_pkg::except_t              d_except_o,
	output rv_decode_pkg::imm_sel_t             imm_sel_o,
	output rv_decode_pkg::offs_sel_t            offs_sel_o
);

	rv_decode_pkg::opcode_t opcode;
	logic [2:0]             funct3;
	logic                   f7_base;
	logic                   f7_alt;
	logic                   bus_fault;
	logic                   invalid;

	// Shared funct3 table of OP and OP-IMM
	function automatic rv_decode_pkg::aluop_t alu_from_funct3(
		input logic [2:0] f3,
		input logic       alt
	);
		rv_decode_pkg::aluop_t op;
		case (f3)
		3'b000:  op = alt ? rv_decode_pkg::ALUOP_SUB : rv_decode_pkg::ALUOP_ADD;
		3'b001:  op = rv_decode_pkg::ALUOP_SLL;
		3'b010:  op = rv_decode_pkg::ALUOP_LT;
		3'b011:  op = rv_decode_pkg::ALUOP_LTU;
		3'b100:  op = rv_decode_pkg::ALUOP_XOR;
		3'b101:  op = alt ? rv_decode_pkg::ALUOP_SRA : rv_decode_pkg::ALUOP_SRL;
		3'b110:  op = rv_decode_pkg::ALUOP_OR;
		default: op = rv_decode_pkg::ALUOP_AND;
		endcase
		return op;
	endfunction

	assign opcode  = rv_decode_pkg::opcode_t'(instr_i[6:2]);
	assign funct3  = instr_i[14:12];
	assign f7_base = instr_i[31:25] == rv_decode_pkg::F7_BASE;
	assign f7_alt  = instr_i[31:25] == rv_decode_pkg::F7_ALT;

	// The error flag means nothing without a valid instruction
	assign bus_fault = fd_cir_vld_i && fd_cir_err_i;

	always_comb begin
		d_rs1_o             = instr_i[19:15];
		d_rs2_o             = instr_i[24:20];
		d_rd_o              = instr_i[11:7];
		d_alusrc_a_o        = rv_decode_pkg::ALUSRCA_RS1;
		d_alusrc_b_o        = rv_decode_pkg::ALUSRCB_RS2;
		d_aluop_o           = rv_decode_pkg::ALUOP_ADD;
		d_memop_o           = rv_decode_pkg::MEMOP_NONE;
		d_branchcond_o      = rv_decode_pkg::BCOND_NEVER;
		d_addr_is_regoffs_o = 1'b0;
		d_except_o          = rv_decode_pkg::EXCEPT_NONE;
		imm_sel_o           = rv_decode_pkg::IMM_SEL_I;
		offs_sel_o          = rv_decode_pkg::OFFS_SEL_ZERO;
		invalid             = instr_i[1:0] != rv_decode_pkg::OPCODE_LOW;

		case (opcode)
		rv_decode_pkg::OPC_LUI: begin
			d_rs1_o      = rv_decode_pkg::REG_X0;
			d_rs2_o      = rv_decode_pkg::REG_X0;
			d_alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
			d_aluop_o    = rv_decode_pkg::ALUOP_RS2;
			imm_sel_o    = rv_decode_pkg::IMM_SEL_U;
		end
		rv_decode_pkg::OPC_AUIPC: begin
			d_rs1_o      = rv_decode_pkg::REG_X0;
			d_rs2_o      = rv_decode_pkg::REG_X0;
			d_alusrc_a_o = rv_decode_pkg::ALUSRCA_PC;
			d_alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
			imm_sel_o    = rv_decode_pkg::IMM_SEL_U;
		end
		// Jumps compute the link address PC + 4 in the ALU
		rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR: begin
			d_rs2_o        = rv_decode_pkg::REG_X0;
			d_alusrc_a_o   = rv_decode_pkg::ALUSRCA_PC;
			d_alusrc_b_o   = rv_decode_pkg::ALUSRCB_IMM;
			d_branchcond_o = rv_decode_pkg::BCOND_ALWAYS;
			imm_sel_o      = rv_decode_pkg::IMM_SEL_LINK;
			if (opcode == rv_decode_pkg::OPC_JAL) begin
				d_rs1_o    = rv_decode_pkg::REG_X0;
				offs_sel_o = rv_decode_pkg::OFFS_SEL_J;
			end else begin
				d_addr_is_regoffs_o = 1'b1;
				offs_sel_o          = rv_decode_pkg::OFFS_SEL_I;
				invalid             = invalid || funct3 != 3'b000;
			end
		end
		rv_decode_pkg::OPC_BRANCH: begin
			d_rd_o     = rv_decode_pkg::REG_X0;
			offs_sel_o = rv_decode_pkg::OFFS_SEL_B;
			// funct3[2:1] picks the compare, funct3[0] inverts the sense
			case (funct3[2:1])
			2'b00:   d_aluop_o = rv_decode_pkg::ALUOP_SUB;
			2'b10:   d_aluop_o = rv_decode_pkg::ALUOP_LT;
			2'b11:   d_aluop_o = rv_decode_pkg::ALUOP_LTU;
			default: invalid = 1'b1;
			endcase
			if (funct3[2] ^ funct3[0])
				d_branchcond_o = rv_decode_pkg::BCOND_NZERO;
			else
				d_branchcond_o = rv_decode_pkg::BCOND_ZERO;
		end
		rv_decode_pkg::OPC_LOAD: begin
			d_rs2_o             = rv_decode_pkg::REG_X0;
			d_addr_is_regoffs_o = 1'b1;
			offs_sel_o          = rv_decode_pkg::OFFS_SEL_I;
			case (funct3)
			3'b000:  d_memop_o = rv_decode_pkg::MEMOP_LB;
			3'b001:  d_memop_o = rv_decode_pkg::MEMOP_LH;
			3'b010:  d_memop_o = rv_decode_pkg::MEMOP_LW;
			3'b100:  d_memop_o = rv_decode_pkg::MEMOP_LBU;
			3'b101:  d_memop_o = rv_decode_pkg::MEMOP_LHU;
			default: invalid = 1'b1;
			endcase
		end
		rv_decode_pkg::OPC_STORE: begin
			d_rd_o              = rv_decode_pkg::REG_X0;
			d_aluop_o           = rv_decode_pkg::ALUOP_RS2;
			d_addr_is_regoffs_o = 1'b1;
			offs_sel_o          = rv_decode_pkg::OFFS_SEL_S;
			case (funct3)
			3'b000:  d_memop_o = rv_decode_pkg::MEMOP_SB;
			3'b001:  d_memop_o = rv_decode_pkg::MEMOP_SH;
			3'b010:  d_memop_o = rv_decode_pkg::MEMOP_SW;
			default: invalid = 1'b1;
			endcase
		end
		rv_decode_pkg::OPC_OP_IMM: begin
			d_rs2_o      = rv_decode_pkg::REG_X0;
			d_alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
			// Only SRAI reads funct7 as an opcode modifier
			d_aluop_o    = alu_from_funct3(funct3, f7_alt && funct3 == 3'b101);
			if (funct3 == 3'b001 && !f7_base)
				invalid = 1'b1;
			if (funct3 == 3'b101 && !(f7_base || f7_alt))
				invalid = 1'b1;
		end
		rv_decode_pkg::OPC_OP: begin
			d_aluop_o = alu_from_funct3(funct3, f7_alt);
			if (!(f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))))
				invalid = 1'b1;
		end
		// FENCE executes as a no-op in an in-order core
		rv_decode_pkg::OPC_MISC_MEM: begin
			d_rs2_o    = rv_decode_pkg::REG_X0;
			offs_sel_o = rv_decode_pkg::OFFS_SEL_FOUR;
			invalid    = invalid || funct3 != 3'b000;
		end
		default: invalid = 1'b1;
		endcase

		if (invalid || starved_i || bus_fault) begin
			d_rs1_o        = rv_decode_pkg::REG_X0;
			d_rs2_o        = rv_decode_pkg::REG_X0;
			d_rd_o         = rv_decode_pkg::REG_X0;
			d_memop_o      = rv_decode_pkg::MEMOP_NONE;
			d_branchcond_o = rv_decode_pkg::BCOND_NEVER;
			if (bus_fault)
				d_except_o = rv_decode_pkg::EXCEPT_INSTR_FAULT;
			else if (invalid && !starved_i)
				d_except_o = rv_decode_pkg::EXCEPT_INSTR_ILLEGAL;
		end

		// The jump of a locked instruction has already been taken
		if (lock_prev_i)
			d_branchcond_o = rv_decode_pkg::BCOND_NEVER;
	end

endmodule

`default_nettype wire

/* hw/rv_pc_ctrl.sv */
// ----------------------------------------------------------
// Decode PC and instruction-register lock control
// Holds the program counter of the instruction in decode,
// derives consume and starve flags and locks the
// instruction register while a decode jump waits on a stall
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rv_pc_ctrl (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            fd_cir_vld_i,
	input  wire                            x_stall_i,
	input  wire                            f_jump_now_i,
	input  wire                            x_jump_not_except_i,
	input  wire  [rv_decode_pkg::XLEN-1:0] f_jump_target_i,
	output logic                           df_cir_use_o,
	output logic                           df_cir_lock_o,
	output logic                           d_starved_o,
	output logic                           lock_prev_o,
	output logic [rv_decode_pkg::XLEN-1:0] d_pc_o
);

	logic                           d_stall;
	logic                           jump_by_d;
	logic                           assert_lock;
	logic                           release_lock;
	logic                           lock_prev;
	logic [rv_decode_pkg::XLEN-1:0] pc;

	// ----------------------------------------------------------
	// Handshake with fetch

	assign d_starved_o  = !fd_cir_vld_i;
	assign d_stall      = x_stall_i || d_starved_o;
	assign df_cir_use_o = !d_stall;

	// ----------------------------------------------------------
	// Lock
	// A jump taken by the instruction in decode while it cannot
	// retire keeps that instruction in place, so its link write
	// and other side effects survive the stall

	assign jump_by_d     = f_jump_now_i && x_jump_not_except_i;
	assign assert_lock   = jump_by_d && d_stall;
	assign release_lock  = lock_prev && !d_stall;
	assign df_cir_lock_o = (lock_prev && d_stall) || assert_lock;
	assign lock_prev_o   = lock_prev;
	assign d_pc_o        = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_prev <= 1'b0;
			pc        <= rv_decode_pkg::RESET_VECTOR;
		end else begin
			lock_prev <= df_cir_lock_o;
			// Fetch holds the target steady until the lock releases
			if ((f_jump_now_i && !assert_lock) || release_lock) begin
				pc <= f_jump_target_i;
			end else if (!d_stall) begin
				pc <= pc + rv_decode_pkg::INSTR_BYTES;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/rv_decode_stage.sv */
// ----------------------------------------------------------
// RV32I decode stage
// Connects PC and lock control, the operation decoder and
// the immediate generator between fetch and execute
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rv_decode_stage (
	input  wire                                 clk,
	input  wire                                 rst_n,

	// Fetch side
	input  wire  [rv_decode_pkg::XLEN-1:0]      fd_cir_i,
	input  wire                                 fd_cir_vld_i,
	input  wire                                 fd_cir_err_i,
	output wire                                 df_cir_use_o,
	output wire                                 df_cir_lock_o,
	output wire  [rv_decode_pkg::XLEN-1:0]      d_pc_o,
	output wire                                 d_starved_o,

	// Execute and jump side
	input  wire                                 x_stall_i,
	input  wire                                 x_jump_not_except_i,
	input  wire                                 f_jump_now_i,
	input  wire  [rv_decode_pkg::XLEN-1:0]      f_jump_target_i,

	// Decoded fields
	output wire  [rv_decode_pkg::XLEN-1:0]      d_imm_o,
	output wire  [rv_decode_pkg::REGADDR_W-1:0] d_rs1_o,
	output wire  [rv_decode_pkg::REGADDR_W-1:0] d_rs2_o,
	output wire  [rv_decode_pkg::REGADDR_W-1:0] d_rd_o,
	output wire  rv_decode_pkg::alusrc_a_t      d_alusrc_a_o,
	output wire  rv_decode_pkg::alusrc_b_t      d_alusrc_b_o,
	output wire  rv_decode_pkg::aluop_t         d_aluop_o,
	output wire  rv_decode_pkg::memop_t         d_memop_o,
	output wire  rv_decode_pkg::bcond_t         d_branchcond_o,
	output wire  [rv_decode_pkg::XLEN-1:0]      d_addr_offs_o,
	output wire                                 d_addr_is_regoffs_o,
	output wire  rv_decode_pkg::except_t        d_except_o
);

	wire                            lock_prev;
	wire rv_decode_pkg::imm_sel_t   imm_sel;
	wire rv_decode_pkg::offs_sel_t  offs_sel;

	rv_pc_ctrl u_pc_ctrl (
		.clk                 (clk),
		.rst_n               (rst_n),
		.fd_cir_vld_i        (fd_cir_vld_i),
		.x_stall_i           (x_stall_i),
		.f_jump_now_i        (f_jump_now_i),
		.x_jump_not_except_i (x_jump_not_except_i),
		.f_jump_target_i     (f_jump_target_i),
		.df_cir_use_o        (df_cir_use_o),
		.df_cir_lock_o       (df_cir_lock_o),
		.d_starved_o         (d_starved_o),
		.lock_prev_o         (lock_prev),
		.d_pc_o              (d_pc_o)
	);

	rv_op_decoder u_op_decoder (
		.instr_i             (fd_cir_i),
		.starved_i           (d_starved_o),
		.fd_cir_vld_i        (fd_cir_vld_i),
		.fd_cir_err_i        (fd_cir_err_i),
		.lock_prev_i         (lock_prev),
		.d_rs1_o             (d_rs1_o),
		.d_rs2_o             (d_rs2_o),
		.d_rd_o              (d_rd_o),
		.d_alusrc_a_o        (d_alusrc_a_o),
		.d_alusrc_b_o        (d_alusrc_b_o),
		.d_aluop_o           (d_aluop_o),
		.d_memop_o           (d_memop_o),
		.d_branchcond_o      (d_branchcond_o),
		.d_addr_is_regoffs_o (d_addr_is_regoffs_o),
		.d_except_o          (d_except_o),
		.imm_sel_o           (imm_sel),
		.offs_sel_o          (offs_sel)
	);

	rv_imm_gen u_imm_gen (
		.instr_i       (fd_cir_i),
		.imm_sel_i     (imm_sel),
		.offs_sel_i    (offs_sel),
		.d_imm_o       (d_imm_o),
		.d_addr_offs_o (d_addr_offs_o)
	);

endmodule

`default_nettype wire

/* sim/rv_decode_sva.sv */
// ----------------------------------------------------------
// Assertions on the decode PC and lock control
// Lock state after reset and the consume flag against
// lock and execute stall
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rv_decode_sva (
	input wire clk,
	input wire rst_n,
	input wire x_stall_i,
	input wire df_cir_use_o,
	input wire df_cir_lock_o,
	input wire lock_prev_o
);

	// Lock state is clear while in reset
	lock_clear_in_reset: assert property (@(posedge clk)
		!rst_n |-> !lock_prev_o && !df_cir_lock_o)
		else $error("lock state set during reset");

	// A locked instruction is never consumed
	no_use_while_locked: assert property (@(posedge clk) disable iff (!rst_n)
		df_cir_lock_o |-> !df_cir_use_o)
		else $error("use flag high while the lock is high");

	no_use_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		x_stall_i |-> !df_cir_use_o)
		else $error("use flag high during an execute stall");

endmodule

bind rv_pc_ctrl rv_decode_sva u_decode_sva (.*);

`default_nettype wire

/* sim/tb_rv_decode.sv */
// ----------------------------------------------------------
// Testbench for the RV32I decode stage
// Drives random and directed instruction streams, predicts
// every decode field and the PC and lock state, and
// compares them with the DUT every cycle
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_rv_decode;

	typedef struct packed {
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic        srca;
		logic        srcb;
		logic [3:0]  aluop;
		logic [3:0]  memop;
		logic [1:0]  bcond;
		logic        regoffs;
		logic [1:0]  exc;
		logic [31:0] imm;
		logic [31:0] offs;
		// Low when the instruction is squashed and only the squashed fields count
		logic        full;
	} dec_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] fd_cir_i;
	logic        fd_cir_vld_i;
	logic        fd_cir_err_i;
	logic        x_stall_i;
	logic        x_jump_not_except_i;
	logic        f_jump_now_i;
	logic [31:0] f_jump_target_i;

	wire         df_cir_use_o;
	wire         df_cir_lock_o;
	wire  [31:0] d_pc_o;
	wire         d_starved_o;
	wire  [31:0] d_imm_o;
	wire  [4:0]  d_rs1_o;
	wire  [4:0]  d_rs2_o;
	wire  [4:0]  d_rd_o;
	wire         d_alusrc_a_o;
	wire         d_alusrc_b_o;
	wire  [3:0]  d_aluop_o;
	wire  [3:0]  d_memop_o;
	wire  [1:0]  d_branchcond_o;
	wire  [31:0] d_addr_offs_o;
	wire         d_addr_is_regoffs_o;
	wire  [1:0]  d_except_o;

	integer      seed;
	int          errors;
	int          checks;

	// Model of the PC and lock state
	logic        m_lock_prev;
	logic [31:0] m_pc;
	wire         m_stall;
	wire         m_lock;

	rv_decode_stage rv_decode_stage_i (.*);

	always #10 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------------------------
	// Reference decode

	function automatic dec_t rv_ref_decode(input logic [31:0] w, input logic vld,
			input logic err, input logic lock_prev);
		dec_t        r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [3:0]  arith;
		logic        bad;
		f3  = w[14:12];
		f7  = w[31:25];
		bad = 1'b0;
		case (f3)
		3'd0: arith = rv_decode_pkg::ALUOP_ADD;
		3'd1: arith = rv_decode_pkg::ALUOP_SLL;
		3'd2: arith = rv_decode_pkg::ALUOP_LT;
		3'd3: arith = rv_decode_pkg::ALUOP_LTU;
		3'd4: arith = rv_decode_pkg::ALUOP_XOR;
		3'd5: arith = rv_decode_pkg::ALUOP_SRL;
		3'd6: arith = rv_decode_pkg::ALUOP_OR;
		default: arith = rv_decode_pkg::ALUOP_AND;
		endcase
		r.rs1     = w[19:15];
		r.rs2     = w[24:20];
		r.rd      = w[11:7];
		r.srca    = rv_decode_pkg::ALUSRCA_RS1;
		r.srcb    = rv_decode_pkg::ALUSRCB_RS2;
		r.aluop   = rv_decode_pkg::ALUOP_ADD;
		r.memop   = rv_decode_pkg::MEMOP_NONE;
		r.bcond   = rv_decode_pkg::BCOND_NEVER;
		r.regoffs = 1'b0;
		r.exc     = rv_decode_pkg::EXCEPT_NONE;
		r.imm     = {{20{w[31]}}, w[31:20]};
		r.offs    = 32'h0;
		r.full    = 1'b1;
		case (w[6:0])
		7'b0110111, 7'b0010111: begin
			r.rs1  = 5'd0;
			r.rs2  = 5'd0;
			r.srcb = rv_decode_pkg::ALUSRCB_IMM;
			r.imm  = {w[31:12], 12'h000};
			if (w[5])
				r.aluop = rv_decode_pkg::ALUOP_RS2;
			else
				r.srca = rv_decode_pkg::ALUSRCA_PC;
		end
		7'b1101111, 7'b1100111: begin
			r.rs2   = 5'd0;
			r.srca  = rv_decode_pkg::ALUSRCA_PC;
			r.srcb  = rv_decode_pkg::ALUSRCB_IMM;
			r.bcond = rv_decode_pkg::BCOND_ALWAYS;
			r.imm   = 32'd4;
			if (w[3]) begin
				r.rs1  = 5'd0;
				r.offs = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end else begin
				r.regoffs = 1'b1;
				r.offs    = {{20{w[31]}}, w[31:20]};
				bad       = f3 != 3'b000;
			end
		end
		7'b1100011: begin
			r.rd   = 5'd0;
			r.offs = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			case (f3)
			3'b000, 3'b001: r.aluop = rv_decode_pkg::ALUOP_SUB;
			3'b100, 3'b101: r.aluop = rv_decode_pkg::ALUOP_LT;
			3'b110, 3'b111: r.aluop = rv_decode_pkg::ALUOP_LTU;
			default:        bad = 1'b1;
			endcase
			// BNE, BLT and BLTU take the branch on a nonzero result
			if (f3 == 3'b001 || f3 == 3'b100 || f3 == 3'b110)
				r.bcond = rv_decode_pkg::BCOND_NZERO;
			else
				r.bcond = rv_decode_pkg::BCOND_ZERO;
		end
		7'b0000011: begin
			r.rs2     = 5'd0;
			r.regoffs = 1'b1;
			r.offs    = {{20{w[31]}}, w[31:20]};
			case (f3)
			3'b000:  r.memop = rv_decode_pkg::MEMOP_LB;
			3'b001:  r.memop = rv_decode_pkg::MEMOP_LH;
			3'b010:  r.memop = rv_decode_pkg::MEMOP_LW;
			3'b100:  r.memop = rv_decode_pkg::MEMOP_LBU;
			3'b101:  r.memop = rv_decode_pkg::MEMOP_LHU;
			default: bad = 1'b1;
			endcase
		end
		7'b0100011: begin
			r.rd      = 5'd0;
			r.aluop   = rv_decode_pkg::ALUOP_RS2;
			r.regoffs = 1'b1;
			r.offs    = {{20{w[31]}}, w[31:25], w[11:7]};
			case (f3)
			3'b000:  r.memop = rv_decode_pkg::MEMOP_SB;
			3'b001:  r.memop = rv_decode_pkg::MEMOP_SH;
			3'b010:  r.memop = rv_decode_pkg::MEMOP_SW;
			default: bad = 1'b1;
			endcase
		end
		7'b0010011: begin
			r.rs2   = 5'd0;
			r.srcb  = rv_decode_pkg::ALUSRCB_IMM;
			r.aluop = arith;
			if (f3 == 3'b001 && f7 != 7'h00)
				bad = 1'b1;
			if (f3 == 3'b101 && f7 == 7'h20)
				r.aluop = rv_decode_pkg::ALUOP_SRA;
			else if (f3 == 3'b101 && f7 != 7'h00)
				bad = 1'b1;
		end
		7'b0110011: begin
			if (f7 == 7'h00)
				r.aluop = arith;
			else if (f7 == 7'h20 && f3 == 3'b000)
				r.aluop = rv_decode_pkg::ALUOP_SUB;
			else if (f7 == 7'h20 && f3 == 3'b101)
				r.aluop = rv_decode_pkg::ALUOP_SRA;
			else
				bad = 1'b1;
		end
		7'b0001111: begin
			r.rs2  = 5'd0;
			r.offs = 32'd4;
			bad    = f3 != 3'b000;
		end
		default: bad = 1'b1;
		endcase
		if (!vld || err || bad) begin
			r.rs1   = 5'd0;
			r.rs2   = 5'd0;
			r.rd    = 5'd0;
			r.memop = rv_decode_pkg::MEMOP_NONE;
			r.bcond = rv_decode_pkg::BCOND_NEVER;
			r.full  = 1'b0;
			if (vld && err)
				r.exc = rv_decode_pkg::EXCEPT_INSTR_FAULT;
			else if (vld)
				r.exc = rv_decode_pkg::EXCEPT_INSTR_ILLEGAL;
		end
		if (lock_prev)
			r.bcond = rv_decode_pkg::BCOND_NEVER;
		return r;
	endfunction

	// ----------------------------------------------------------
	// PC and lock model, compare process

	assign m_stall = x_stall_i || !fd_cir_vld_i;
	assign m_lock  = m_stall && (m_lock_prev || (f_jump_now_i && x_jump_not_except_i));

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_lock_prev <= 1'b0;
			m_pc        <= rv_decode_pkg::RESET_VECTOR;
		end else begin
			m_lock_prev <= m_lock;
			if (m_lock_prev && !m_stall)
				m_pc <= f_jump_target_i;
			else if (f_jump_now_i && !(m_stall && x_jump_not_except_i))
				m_pc <= f_jump_target_i;
			else if (!m_stall)
				m_pc <= m_pc + 32'd4;
		end
	end

	always @(negedge clk) begin
		dec_t e;
		if (rst_n) begin
			e = rv_ref_decode(fd_cir_i, fd_cir_vld_i, fd_cir_err_i, m_lock_prev);
			check_value("rs1", 32'(d_rs1_o), 32'(e.rs1));
			check_value("rs2", 32'(d_rs2_o), 32'(e.rs2));
			check_value("rd", 32'(d_rd_o), 32'(e.rd));
			check_value("memop", 32'(d_memop_o), 32'(e.memop));
			check_value("branch condition", 32'(d_branchcond_o), 32'(e.bcond));
			check_value("exception", 32'(d_except_o), 32'(e.exc));
			if (e.full) begin
				check_value("alusrc a", 32'(d_alusrc_a_o), 32'(e.srca));
				check_value("alusrc b", 32'(d_alusrc_b_o), 32'(e.srcb));
				check_value("aluop", 32'(d_aluop_o), 32'(e.aluop));
				check_value("immediate", d_imm_o, e.imm);
				check_value("address offset", d_addr_offs_o, e.offs);
				check_value("address base", 32'(d_addr_is_regoffs_o), 32'(e.regoffs));
			end
			check_value("use flag", 32'(df_cir_use_o), 32'(!m_stall));
			check_value("lock flag", 32'(df_cir_lock_o), 32'(m_lock));
			check_value("starved flag", 32'(d_starved_o), 32'(!fd_cir_vld_i));
			check_value("pc", d_pc_o, m_pc);
		end
	end

	// ----------------------------------------------------------
	// Stimulus

	task automatic drive(input logic [31:0] w, input logic vld, input logic err,
			input logic stall, input logic jmp, input logic jne, input logic [31:0] tgt);
		@(posedge clk);
		#1;
		fd_cir_i            = w;
		fd_cir_vld_i        = vld;
		fd_cir_err_i        = err;
		x_stall_i           = stall;
		f_jump_now_i        = jmp;
		x_jump_not_except_i = jne;
		f_jump_target_i     = tgt;
	endtask

	// Kinds 0 to 9 are OP, OP-IMM, LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC, FENCE
	task automatic make_instr(input int kind, output logic [31:0] w);
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r  = $random(seed);
		f3 = r[14:12];
		f7 = 7'h00;
		case (kind)
		0: begin
			if ((f3 == 3'b000 || f3 == 3'b101) && r[30])
				f7 = 7'h20;
			w = {f7, r[24:15], f3, r[11:7], 7'b0110011};
		end
		1: begin
			f7 = r[31:25];
			if (f3 == 3'b001)
				f7 = 7'h00;
			if (f3 == 3'b101)
				f7 = r[30] ? 7'h20 : 7'h00;
			w = {f7, r[24:15], f3, r[11:7], 7'b0010011};
		end
		2: begin
			if (f3 == 3'b011 || f3[2:1] == 2'b11)
				f3 = 3'b010;
			w = {r[31:15], f3, r[11:7], 7'b0000011};
		end
		3: w = {r[31:15], 1'b0, (r[13:12] == 2'b11) ? 2'b10 : r[13:12], r[11:7], 7'b0100011};
		4: begin
			if (f3[2:1] == 2'b01)
				f3 = 3'b000;
			w = {r[31:15], f3, r[11:7], 7'b1100011};
		end
		5: w = {r[31:7], 7'b1101111};
		6: w = {r[31:15], 3'b000, r[11:7], 7'b1100111};
		7: w = {r[31:7], 7'b0110111};
		8: w = {r[31:7], 7'b0010111};
		9: w = {r[31:15], 3'b000, r[11:7], 7'b0001111};
		default: begin
			// Compressed low bits, a SYSTEM opcode or a multiply funct7
			case (r[1:0])
			2'b00:   w = {r[31:2], 2'b01};
			2'b01:   w = {r[31:7], 7'b1110011};
			default: w = {7'h01, r[24:7], 7'b0110011};
			endcase
		end
		endcase
	endtask

	task automatic wait_use(input int limit);
		int n;
		n = 0;
		while (!df_cir_use_o && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!df_cir_use_o) begin
			errors++;
			$display("Timeout: use flag stayed low for %0d cycles after the stall", limit);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] w;
		int          kind;
		clk                 = 1'b0;
		rst_n               = 1'b0;
		fd_cir_i            = 32'h0;
		fd_cir_vld_i        = 1'b0;
		fd_cir_err_i        = 1'b0;
		x_stall_i           = 1'b0;
		x_jump_not_except_i = 1'b0;
		f_jump_now_i        = 1'b0;
		f_jump_target_i     = 32'h0;
		seed                = 32'h3654_bbb9;
		errors              = 0;
		checks              = 0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Random streams: ALU, then memory and control flow, then faults and illegal words
		for (int n = 0; n < 600; n++) begin
			rnd = $random(seed);
			if (n < 200)
				kind = int'(rnd[8]);
			else if (n < 400)
				kind = 2 + int'(rnd[10:8]);
			else
				kind = rnd[16] ? 10 : int'(rnd[11:8]) % 10;
			make_instr(kind, w);
			if (n < 400)
				drive(w, rnd[2:0] != 3'b000, 1'b0, rnd[7:6] == 2'b00, 1'b0, 1'b0, rnd);
			else
				drive(w, rnd[1:0] != 2'b00, rnd[5:4] == 2'b00, rnd[7:6] == 2'b00,
					1'b0, 1'b0, rnd);
		end

		// Jump without a stall
		make_instr(5, w);
		drive(w, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_2000);
		drive(w, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
		@(negedge clk);
		check_value("pc after jump", d_pc_o, 32'h0000_2000);

		// Jump during a stall locks the instruction register
		drive(w, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0000_3000);
		@(negedge clk);
		check_value("lock raised", 32'(df_cir_lock_o), 32'd1);
		repeat (2) begin
			drive(w, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_3000);
			@(negedge clk);
			check_value("lock held", 32'(df_cir_lock_o), 32'd1);
			check_value("locked branch", 32'(d_branchcond_o), 32'(rv_decode_pkg::BCOND_NEVER));
		end
		drive(w, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_3000);
		@(negedge clk);
		wait_use(8);
		check_value("lock released", 32'(df_cir_lock_o), 32'd0);
		drive(32'h0000_0013, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
		@(negedge clk);
		check_value("pc after locked jump", d_pc_o, 32'h0000_3000);
		drive(32'h0000_0013, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);

		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hw/rv_decode_pkg.sv
hw/rv_imm_gen.sv
hw/rv_op_decoder.sv
hw/rv_pc_ctrl.sv
hw/rv_decode_stage.sv
sim/rv_decode_sva.sv
sim/tb_rv_decode.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_rv_decode: tb.f $(SRCS)
	verilator --binary --assert --top-module tb_rv_decode -f tb.f

run: obj_dir/Vtb_rv_decode
	./obj_dir/Vtb_rv_decode | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
